// ==== hw/core_tap_pkg.sv ====
`default_nettype none

package core_tap_pkg;

    // Core bus widths
    localparam int unsigned WORD_W    = 32;
    localparam int unsigned ADDR_W    = 32;
    localparam int unsigned REG_IDX_W = 5;
    localparam int unsigned HAZARD_W  = 16;

    // Architectural register count
    localparam int unsigned NUM_REGS   = 32;
    // Bytes in one data word
    localparam int unsigned WORD_BYTES = 4;

    // Data word, byte address, register index
    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Raw hazard unit status
    typedef logic [HAZARD_W-1:0]  hazard_t;

endpackage

`default_nettype wire

// ==== hw/dump_proto_pkg.sv ====
`default_nettype none

package dump_proto_pkg;

    // UART symbol width
    localparam int unsigned BYTE_W = 8;

    typedef logic [BYTE_W-1:0] byte_t;
    // Byte lane inside a word, 0 is least significant
    typedef logic [1:0]        byte_idx_t;
    // Word index inside the pipeline snapshot
    typedef logic [1:0]        pipe_idx_t;

    // First byte of every dump
    localparam byte_t DUMP_ALERT = 8'hDA;
    // Hazard word plus the three IF/ID fields
    localparam int unsigned PIPE_WORDS = 4;

    // Dump sections in stream order
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        REGS,
        PIPE,
        MEM_MIN,
        MEM_MAX,
        MEM_DATA,
        DONE
    } dump_state_t;

endpackage

`default_nettype wire

// ==== hw/pipe_snapshot_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_snapshot_mux (
    // Snapshot word select from the sequencer
    input  wire dump_proto_pkg::pipe_idx_t pipe_idx_i,

    // Core pipeline taps
    input  wire core_tap_pkg::hazard_t     hazard_status_i,
    input  wire core_tap_pkg::word_t       if_id_pc_i,
    input  wire core_tap_pkg::word_t       if_id_instr_i,
    input  wire core_tap_pkg::word_t       if_id_pc4_i,

    // Selected snapshot word
    output core_tap_pkg::word_t            pipe_word_o
);

    // Hazard status widened to a full word, upper bits zero
    core_tap_pkg::word_t hazard_word;

    assign hazard_word = core_tap_pkg::word_t'(hazard_status_i);

    // ------------------------------------------------
    // Snapshot word map
    // ------------------------------------------------
    always_comb begin
        case (pipe_idx_i)
            // Word 0, hazard status
            2'd0: pipe_word_o = hazard_word;
            // Words 1 to 3, IF/ID register fields
            2'd1: pipe_word_o = if_id_pc_i;
            2'd2: pipe_word_o = if_id_instr_i;
            2'd3: pipe_word_o = if_id_pc4_i;
            default: pipe_word_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/byte_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_serializer (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // Word strobe from the sequencer
    input  wire logic                   word_valid_i,
    input  wire core_tap_pkg::word_t    word_i,

    // UART transmit side
    output dump_proto_pkg::byte_t       tx_data_o,
    output logic                        tx_start_o,
    input  wire logic                   tx_done_i,

    // One-cycle pulse once the last byte is acknowledged
    output logic                        word_done_o
);

    // Word being shifted out
    core_tap_pkg::word_t       word_q;
    // Current byte lane
    dump_proto_pkg::byte_idx_t byte_idx_q;
    // A byte is out on the UART and not yet acknowledged
    logic                      waiting_q;
    logic                      last_byte;

    assign last_byte = (byte_idx_q == dump_proto_pkg::byte_idx_t'(core_tap_pkg::WORD_BYTES - 1));

    // Little-endian lane select
    assign tx_data_o = word_q[{byte_idx_q, 3'b000} +: 8];

    // ------------------------------------------------
    // Word capture
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (word_valid_i) begin
            word_q <= word_i;
        end
    end

    // ------------------------------------------------
    // Byte handshake
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            byte_idx_q  <= '0;
            waiting_q   <= 1'b0;
            tx_start_o  <= 1'b0;
            word_done_o <= 1'b0;
        end else begin
            // Strobes last a single cycle
            tx_start_o  <= 1'b0;
            word_done_o <= 1'b0;
            if (word_valid_i) begin
                // New word, start with byte 0 on the next cycle
                byte_idx_q <= '0;
                waiting_q  <= 1'b1;
                tx_start_o <= 1'b1;
            end else if (waiting_q && tx_done_i) begin
                if (last_byte) begin
                    waiting_q   <= 1'b0;
                    word_done_o <= 1'b1;
                end else begin
                    // Next lane goes out right after the ack
                    byte_idx_q <= byte_idx_q + 2'd1;
                    tx_start_o <= 1'b1;
                end
            end
            // Stray tx_done_i with nothing outstanding falls through
        end
    end

endmodule

`default_nettype wire

// ==== hw/dump_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dump_sequencer (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,

    // Dump request from the debug side
    input  wire logic                    dump_trigger_i,

    // Serializer handshake
    input  wire logic                    word_done_i,
    output logic                         word_valid_o,
    output core_tap_pkg::word_t          word_o,

    // Register file debug port
    output core_tap_pkg::reg_idx_t       rf_dbg_addr_o,
    input  wire core_tap_pkg::word_t     rf_dbg_data_i,

    // Pipeline snapshot select
    output dump_proto_pkg::pipe_idx_t    pipe_idx_o,
    input  wire core_tap_pkg::word_t     pipe_word_i,

    // Data memory port
    output core_tap_pkg::addr_t          dmem_addr_o,
    input  wire core_tap_pkg::word_t     dmem_data_i,
    output logic                         dump_needs_mem_o,

    // Memory range bounds
    input  wire core_tap_pkg::addr_t     min_addr_i,
    input  wire core_tap_pkg::addr_t     max_addr_i,

    output logic                         dump_done_o
);

    dump_proto_pkg::dump_state_t state_q;

    // Range bounds frozen for the whole dump
    core_tap_pkg::addr_t min_q;
    core_tap_pkg::addr_t max_q;

    logic start_dump;
    logic last_reg;
    logic last_pipe;
    logic last_mem;

    assign start_dump = (state_q == dump_proto_pkg::IDLE) && dump_trigger_i;
    assign last_reg   = (rf_dbg_addr_o == core_tap_pkg::reg_idx_t'(core_tap_pkg::NUM_REGS - 1));
    assign last_pipe  = (pipe_idx_o == dump_proto_pkg::pipe_idx_t'(dump_proto_pkg::PIPE_WORDS - 1));
    // Stop once the address reaches max, so min > max still sends one word
    assign last_mem   = (dmem_addr_o >= max_q);

    // ------------------------------------------------
    // Range latch
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (start_dump) begin
            min_q <= min_addr_i;
            max_q <= max_addr_i;
        end
    end

    // ------------------------------------------------
    // Section walk
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= dump_proto_pkg::IDLE;
            word_valid_o  <= 1'b0;
            rf_dbg_addr_o <= '0;
            pipe_idx_o    <= '0;
            dmem_addr_o   <= '0;
        end else begin
            word_valid_o <= 1'b0;
            case (state_q)
                dump_proto_pkg::IDLE: begin
                    if (dump_trigger_i) begin
                        // Header goes out on the next cycle
                        state_q       <= dump_proto_pkg::HEADER;
                        word_valid_o  <= 1'b1;
                        rf_dbg_addr_o <= '0;
                        pipe_idx_o    <= '0;
                        dmem_addr_o   <= min_addr_i;
                    end
                end
                dump_proto_pkg::HEADER: begin
                    if (word_done_i) begin
                        state_q      <= dump_proto_pkg::REGS;
                        word_valid_o <= 1'b1;
                    end
                end
                dump_proto_pkg::REGS: begin
                    if (word_done_i) begin
                        word_valid_o <= 1'b1;
                        if (last_reg) begin
                            state_q <= dump_proto_pkg::PIPE;
                        end else begin
                            rf_dbg_addr_o <= rf_dbg_addr_o + core_tap_pkg::reg_idx_t'(1);
                        end
                    end
                end
                dump_proto_pkg::PIPE: begin
                    if (word_done_i) begin
                        word_valid_o <= 1'b1;
                        if (last_pipe) begin
                            state_q <= dump_proto_pkg::MEM_MIN;
                        end else begin
                            pipe_idx_o <= pipe_idx_o + dump_proto_pkg::pipe_idx_t'(1);
                        end
                    end
                end
                dump_proto_pkg::MEM_MIN: begin
                    if (word_done_i) begin
                        state_q      <= dump_proto_pkg::MEM_MAX;
                        word_valid_o <= 1'b1;
                    end
                end
                dump_proto_pkg::MEM_MAX: begin
                    // Memory address already sits at min
                    if (word_done_i) begin
                        state_q      <= dump_proto_pkg::MEM_DATA;
                        word_valid_o <= 1'b1;
                    end
                end
                dump_proto_pkg::MEM_DATA: begin
                    if (word_done_i) begin
                        if (last_mem) begin
                            state_q <= dump_proto_pkg::DONE;
                        end else begin
                            dmem_addr_o  <= dmem_addr_o + core_tap_pkg::addr_t'(core_tap_pkg::WORD_BYTES);
                            word_valid_o <= 1'b1;
                        end
                    end
                end
                dump_proto_pkg::DONE: begin
                    // Hold until the trigger is released
                    if (!dump_trigger_i) begin
                        state_q <= dump_proto_pkg::IDLE;
                    end
                end
                default: state_q <= dump_proto_pkg::IDLE;
            endcase
        end
    end

    // ------------------------------------------------
    // Outgoing word select
    // ------------------------------------------------
    always_comb begin
        case (state_q)
            // Alert, register count, snapshot size, spare
            dump_proto_pkg::HEADER: word_o = {8'h00,
                                              dump_proto_pkg::byte_t'(dump_proto_pkg::PIPE_WORDS),
                                              dump_proto_pkg::byte_t'(core_tap_pkg::NUM_REGS),
                                              dump_proto_pkg::DUMP_ALERT};
            dump_proto_pkg::REGS:     word_o = rf_dbg_data_i;
            dump_proto_pkg::PIPE:     word_o = pipe_word_i;
            dump_proto_pkg::MEM_MIN:  word_o = min_q;
            dump_proto_pkg::MEM_MAX:  word_o = max_q;
            dump_proto_pkg::MEM_DATA: word_o = dmem_data_i;
            default:                  word_o = '0;
        endcase
    end

    // Memory bus request covers the whole memory section
    assign dump_needs_mem_o = (state_q == dump_proto_pkg::MEM_MIN) ||
                              (state_q == dump_proto_pkg::MEM_MAX) ||
                              (state_q == dump_proto_pkg::MEM_DATA);

    assign dump_done_o = (state_q == dump_proto_pkg::DONE);

endmodule

`default_nettype wire

// ==== hw/dump_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module dump_unit (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // Debug control
    input  wire logic                   dump_trigger_i,
    output logic                        dump_done_o,

    // UART transmit port
    output dump_proto_pkg::byte_t       tx_data_o,
    output logic                        tx_start_o,
    input  wire logic                   tx_done_i,

    // Register file debug port
    output core_tap_pkg::reg_idx_t      rf_dbg_addr_o,
    input  wire core_tap_pkg::word_t    rf_dbg_data_i,

    // Pipeline taps
    input  wire core_tap_pkg::hazard_t  hazard_status_i,
    input  wire core_tap_pkg::word_t    if_id_pc_i,
    input  wire core_tap_pkg::word_t    if_id_instr_i,
    input  wire core_tap_pkg::word_t    if_id_pc4_i,

    // Data memory port and dump range
    output logic                        dump_needs_mem_o,
    output core_tap_pkg::addr_t         dmem_addr_o,
    input  wire core_tap_pkg::word_t    dmem_data_i,
    input  wire core_tap_pkg::addr_t    min_addr_i,
    input  wire core_tap_pkg::addr_t    max_addr_i
);

    // Sequencer to serializer
    logic                      word_valid;
    core_tap_pkg::word_t       word;
    logic                      word_done;

    // Sequencer to snapshot mux
    dump_proto_pkg::pipe_idx_t pipe_idx;
    core_tap_pkg::word_t       pipe_word;

    dump_sequencer u_dump_sequencer (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .dump_trigger_i   (dump_trigger_i),
        .word_done_i      (word_done),
        .word_valid_o     (word_valid),
        .word_o           (word),
        .rf_dbg_addr_o    (rf_dbg_addr_o),
        .rf_dbg_data_i    (rf_dbg_data_i),
        .pipe_idx_o       (pipe_idx),
        .pipe_word_i      (pipe_word),
        .dmem_addr_o      (dmem_addr_o),
        .dmem_data_i      (dmem_data_i),
        .dump_needs_mem_o (dump_needs_mem_o),
        .min_addr_i       (min_addr_i),
        .max_addr_i       (max_addr_i),
        .dump_done_o      (dump_done_o)
    );

    pipe_snapshot_mux u_pipe_snapshot_mux (
        .pipe_idx_i      (pipe_idx),
        .hazard_status_i (hazard_status_i),
        .if_id_pc_i      (if_id_pc_i),
        .if_id_instr_i   (if_id_instr_i),
        .if_id_pc4_i     (if_id_pc4_i),
        .pipe_word_o     (pipe_word)
    );

    byte_serializer u_byte_serializer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .word_valid_i (word_valid),
        .word_i       (word),
        .tx_data_o    (tx_data_o),
        .tx_start_o   (tx_start_o),
        .tx_done_i    (tx_done_i),
        .word_done_o  (word_done)
    );

endmodule

`default_nettype wire

// ==== tb/tb_dump_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dump_unit;

    localparam logic [31:0] LFSR_SEED = 32'h6ab5_5220;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // Header, 32 registers, 4 snapshot words, min and max
    localparam int FIXED_WORDS = 39;
    // First byte of the memory section (min word)
    localparam int MEM_FIRST_BYTE = 4 * (FIXED_WORDS - 2);
    // Two dumps with one and six memory words
    localparam int MAX_BYTES = 4 * (2 * FIXED_WORDS + 1 + 6);
    localparam int WATCHDOG_CYCLES = MAX_BYTES * 6 + 400;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic dump_trigger_i;
    logic tx_done_i = 1'b0;
    logic dump_done_o;
    logic tx_start_o;
    logic dump_needs_mem_o;
    dump_proto_pkg::byte_t tx_data_o;
    core_tap_pkg::reg_idx_t rf_dbg_addr_o;
    core_tap_pkg::addr_t dmem_addr_o;
    core_tap_pkg::word_t rf_dbg_data_i;
    core_tap_pkg::word_t dmem_data_i;
    core_tap_pkg::hazard_t hazard_status_i;
    core_tap_pkg::word_t if_id_pc_i;
    core_tap_pkg::word_t if_id_instr_i;
    core_tap_pkg::word_t if_id_pc4_i;
    core_tap_pkg::addr_t min_addr_i;
    core_tap_pkg::addr_t max_addr_i;

    // Register file model and received UART stream
    core_tap_pkg::word_t rf_mem [core_tap_pkg::NUM_REGS];
    dump_proto_pkg::byte_t rx_q[$];
    // dump_needs_mem_o seen with each byte
    logic mem_flag_q[$];
    logic [31:0] data_lfsr_q = LFSR_SEED;
    logic [31:0] ack_lfsr_q = LFSR_SEED;
    logic pending = 1'b0;
    logic prev_start = 1'b0;
    int ack_wait = 0;

    dump_unit u_dump_unit (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .dump_trigger_i   (dump_trigger_i),
        .dump_done_o      (dump_done_o),
        .tx_data_o        (tx_data_o),
        .tx_start_o       (tx_start_o),
        .tx_done_i        (tx_done_i),
        .rf_dbg_addr_o    (rf_dbg_addr_o),
        .rf_dbg_data_i    (rf_dbg_data_i),
        .hazard_status_i  (hazard_status_i),
        .if_id_pc_i       (if_id_pc_i),
        .if_id_instr_i    (if_id_instr_i),
        .if_id_pc4_i      (if_id_pc4_i),
        .dump_needs_mem_o (dump_needs_mem_o),
        .dmem_addr_o      (dmem_addr_o),
        .dmem_data_i      (dmem_data_i),
        .min_addr_i       (min_addr_i),
        .max_addr_i       (max_addr_i)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // Memory contents mixed from every address bit
    function automatic core_tap_pkg::word_t mem_pattern(input core_tap_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]} ^ 32'hc3a5_0f1e;
    endfunction

    // Combinational read ports of the core models
    assign rf_dbg_data_i = rf_mem[rf_dbg_addr_o];
    assign dmem_data_i   = mem_pattern(dmem_addr_o);

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr_q = lfsr_next(data_lfsr_q);
            v = {v[30:0], data_lfsr_q[0]};
        end
    endtask

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "Run stopped at first error");
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_byte(input dump_proto_pkg::byte_t got,
                              input dump_proto_pkg::byte_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input core_tap_pkg::word_t got,
                              input core_tap_pkg::word_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input core_tap_pkg::addr_t got,
                              input core_tap_pkg::addr_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // UART model with an ack after 1 to 4 cycles
    // --------------------------------------------------
    always @(negedge clk_i) begin
        tx_done_i = 1'b0;
        if (ack_wait > 0) begin
            ack_wait = ack_wait - 1;
            if (ack_wait == 0) begin
                tx_done_i = 1'b1;
                pending = 1'b0;
            end
        end
        if (tx_start_o) begin
            if (pending) begin
                $display("tx_start_o pulsed while a byte was still unacknowledged");
                stop_run();
            end
            if (prev_start) begin
                $display("tx_start_o stayed high for more than one cycle");
                stop_run();
            end
            rx_q.push_back(tx_data_o);
            mem_flag_q.push_back(dump_needs_mem_o);
            pending = 1'b1;
            // Two LFSR bits give the ack delay
            ack_lfsr_q = lfsr_next(ack_lfsr_q);
            ack_wait = 1 + int'(ack_lfsr_q[0]);
            ack_lfsr_q = lfsr_next(ack_lfsr_q);
            ack_wait = ack_wait + 2 * int'(ack_lfsr_q[0]);
        end
        prev_start = tx_start_o;
    end

    // Word k of the stream rebuilt least significant byte first
    function automatic core_tap_pkg::word_t stream_word(input int k);
        return {rx_q[4*k+3], rx_q[4*k+2], rx_q[4*k+1], rx_q[4*k]};
    endfunction

    // Memory words from lo in steps of four through the first address at or above hi
    function automatic int mem_word_count(input core_tap_pkg::addr_t lo,
                                          input core_tap_pkg::addr_t hi);
        core_tap_pkg::addr_t a;
        int n;
        a = lo;
        n = 1;
        while (a < hi) begin
            a = a + 32'd4;
            n++;
        end
        return n;
    endfunction

    task automatic load_core_state(input core_tap_pkg::addr_t lo, input core_tap_pkg::addr_t hi);
        logic [31:0] v;
        for (int r = 0; r < 32; r++) begin
            draw_bits(32, v);
            rf_mem[core_tap_pkg::reg_idx_t'(r)] = v;
        end
        draw_bits(16, v);
        hazard_status_i = v[15:0];
        draw_bits(32, v);
        if_id_pc_i = {v[31:2], 2'b00};
        if_id_pc4_i = {v[31:2], 2'b00} + 32'd4;
        draw_bits(32, v);
        if_id_instr_i = v;
        min_addr_i = lo;
        max_addr_i = hi;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic check_handshake(input int n_mem);
        if (rx_q.size() != 4 * (FIXED_WORDS + n_mem)) begin
            $display("Dump sent %0d bytes instead of %0d", rx_q.size(),
                     4 * (FIXED_WORDS + n_mem));
            stop_run();
        end
        check_flag(pending, 1'b0, "byte outstanding at dump_done_o");
    endtask

    task automatic check_header();
        check_byte(rx_q[0], 8'hDA, "header alert byte");
        check_byte(rx_q[1], 8'd32, "header register count");
        check_byte(rx_q[2], 8'd4, "header snapshot size");
        check_byte(rx_q[3], 8'h00, "header spare byte");
    endtask

    task automatic check_registers();
        for (int r = 0; r < 32; r++) begin
            check_word(stream_word(1 + r), rf_mem[core_tap_pkg::reg_idx_t'(r)],
                       $sformatf("register %0d", r));
        end
    endtask

    task automatic check_snapshot();
        check_word(stream_word(33), {16'h0000, hazard_status_i}, "hazard status word");
        check_word(stream_word(34), if_id_pc_i, "IF/ID PC");
        check_word(stream_word(35), if_id_instr_i, "IF/ID instruction");
        check_word(stream_word(36), if_id_pc4_i, "IF/ID PC+4");
    endtask

    task automatic check_memory(input core_tap_pkg::addr_t lo, input core_tap_pkg::addr_t hi);
        core_tap_pkg::addr_t a;
        check_addr(stream_word(37), lo, "range min");
        check_addr(stream_word(38), hi, "range max");
        a = lo;
        for (int k = 0; k < mem_word_count(lo, hi); k++) begin
            check_word(stream_word(FIXED_WORDS + k), mem_pattern(a),
                       $sformatf("memory word at %h", a));
            a = a + 32'd4;
        end
        // Memory request only during the memory section
        for (int b = 0; b < rx_q.size(); b++) begin
            check_flag(mem_flag_q[b], b >= MEM_FIRST_BYTE,
                       $sformatf("dump_needs_mem_o with byte %0d", b));
        end
    endtask

    task automatic check_completion();
        int n_bytes;
        n_bytes = rx_q.size();
        repeat (8) begin
            @(negedge clk_i);
            check_flag(dump_done_o, 1'b1, "dump_done_o with trigger held");
            check_flag(dump_needs_mem_o, 1'b0, "dump_needs_mem_o after the dump");
        end
        dump_trigger_i = 1'b0;
        repeat (4) begin
            @(negedge clk_i);
            check_flag(dump_done_o, 1'b0, "dump_done_o after trigger release");
        end
        if (rx_q.size() != n_bytes) begin
            $display("Bytes were sent after the dump had finished");
            stop_run();
        end
    endtask

    task automatic run_dump(input core_tap_pkg::addr_t lo, input core_tap_pkg::addr_t hi);
        @(negedge clk_i);
        load_core_state(lo, hi);
        rx_q.delete();
        mem_flag_q.delete();
        dump_trigger_i = 1'b1;
        while (!dump_done_o) begin
            @(negedge clk_i);
        end
        check_handshake(mem_word_count(lo, hi));
        check_header();
        check_registers();
        check_snapshot();
        check_memory(lo, hi);
        check_completion();
    endtask

    initial begin
        rst_ni = 1'b0;
        dump_trigger_i = 1'b0;
        load_core_state(32'h0000_0100, 32'h0000_0100);
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_flag(tx_start_o, 1'b0, "tx_start_o after reset");
        check_flag(dump_done_o, 1'b0, "dump_done_o after reset");
        check_flag(dump_needs_mem_o, 1'b0, "dump_needs_mem_o after reset");
        check_addr(dmem_addr_o, 32'h0, "dmem_addr_o after reset");
        // Single word range with min equal to max
        run_dump(32'h0000_0100, 32'h0000_0100);
        // Retrigger with new inputs and max off a word step
        run_dump(32'h0000_0200, 32'h0000_0212);
        $display("All checks passed");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the dumps did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_run();
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/core_tap_pkg.sv
hw/dump_proto_pkg.sv
hw/pipe_snapshot_mux.sv
hw/byte_serializer.sv
hw/dump_sequencer.sv
hw/dump_unit.sv
tb/tb_dump_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_dump_unit -o sim_dump_unit

./obj_dir/sim_dump_unit > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
